//--- common/id_config.svh
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// datapath width
`define ID_XLEN 32

// register file geometry
`define ID_REG_AW 5
`define ID_NUM_REGS 32

// one-hot alu operation
`define ID_ALU_OP_W 12

// bl writes its return address here
`define ID_LINK_REG 1

`endif

//--- common/isa_pkg.sv
`default_nettype none

`include "id_config.svh"

package isa_pkg;

    typedef logic [`ID_REG_AW-1:0] reg_addr_t;
    typedef logic [`ID_XLEN-1:0] word_t;
    typedef logic [`ID_ALU_OP_W-1:0] alu_op_t;
    typedef logic [4:0] load_op_t;
    typedef logic [2:0] store_op_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_JIRL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_kind_t;

    // major opcode, inst[31:26]
    localparam logic [5:0] OP_GRP0 = 6'h00;
    localparam logic [5:0] OP_LU12I = 6'h05;
    localparam logic [5:0] OP_PCADDU12I = 6'h07;
    localparam logic [5:0] OP_MEM = 6'h0a;
    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B = 6'h14;
    localparam logic [5:0] OP_BL = 6'h15;
    localparam logic [5:0] OP_BEQ = 6'h16;
    localparam logic [5:0] OP_BNE = 6'h17;
    localparam logic [5:0] OP_BLT = 6'h18;
    localparam logic [5:0] OP_BGE = 6'h19;
    localparam logic [5:0] OP_BLTU = 6'h1a;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    // bit positions inside alu_op_t
    localparam int ALU_ADD = 0;
    localparam int ALU_SUB = 1;
    localparam int ALU_SLT = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND = 4;
    localparam int ALU_NOR = 5;
    localparam int ALU_OR = 6;
    localparam int ALU_XOR = 7;
    localparam int ALU_SLL = 8;
    localparam int ALU_SRL = 9;
    localparam int ALU_SRA = 10;
    localparam int ALU_LUI = 11;

    typedef struct packed {
        alu_op_t   alu_op;
        load_op_t  load_op;
        store_op_t store_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        word_t     imm;
        br_kind_t  br_kind;
        logic      reads_rj;
        logic      reads_second;
    } decode_ctrl_t;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // fetch to decode
    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fetch_bundle_t;

    // write-back port into the register file
    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t     wdata;
    } wb_bundle_t;

    // one bypass source from a later stage
    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     data;
    } fwd_bundle_t;

    // decode to execute
    typedef struct packed {
        isa_pkg::word_t        pc;
        isa_pkg::word_t        rj_value;
        isa_pkg::word_t        rkd_value;
        isa_pkg::decode_ctrl_t ctrl;
    } issue_bundle_t;

    // branch result back to fetch
    typedef struct packed {
        logic           stall;
        logic           taken;
        logic           cancel;
        isa_pkg::word_t target;
    } branch_bundle_t;

endpackage

`default_nettype wire

//--- source/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_config.svh"

module inst_decoder (
    input  isa_pkg::word_t        inst,
    output isa_pkg::decode_ctrl_t ctrl,
    output isa_pkg::reg_addr_t    raddr1,
    output isa_pkg::reg_addr_t    raddr2
);
    import isa_pkg::*;

    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [1:0] op_21_20;
    logic [4:0] op_19_15;
    reg_addr_t  rd;
    reg_addr_t  rj;
    reg_addr_t  rk;
    word_t      si12;
    word_t      ui20;
    logic       known;
    logic       is_cond;
    logic       src_is_rd;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];
    assign si12 = {{20{inst[21]}}, inst[21:10]};
    assign ui20 = {inst[24:5], 12'b0};

    always_comb begin
        ctrl = '0;
        known = 1'b1;
        ctrl.dest = rd;
        case (op_31_26)
            OP_GRP0: begin
                ctrl.reads_rj = 1'b1;
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    // three-register ops
                    ctrl.reads_second = 1'b1;
                    case (op_19_15)
                        5'h00: ctrl.alu_op[ALU_ADD] = 1'b1;
                        5'h02: ctrl.alu_op[ALU_SUB] = 1'b1;
                        5'h04: ctrl.alu_op[ALU_SLT] = 1'b1;
                        5'h05: ctrl.alu_op[ALU_SLTU] = 1'b1;
                        5'h08: ctrl.alu_op[ALU_NOR] = 1'b1;
                        5'h09: ctrl.alu_op[ALU_AND] = 1'b1;
                        5'h0a: ctrl.alu_op[ALU_OR] = 1'b1;
                        5'h0b: ctrl.alu_op[ALU_XOR] = 1'b1;
                        5'h0e: ctrl.alu_op[ALU_SLL] = 1'b1;
                        5'h0f: ctrl.alu_op[ALU_SRL] = 1'b1;
                        5'h10: ctrl.alu_op[ALU_SRA] = 1'b1;
                        default: known = 1'b0;
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    // shift by ui5
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm = word_t'(rk);
                    case (op_19_15)
                        5'h01: ctrl.alu_op[ALU_SLL] = 1'b1;
                        5'h09: ctrl.alu_op[ALU_SRL] = 1'b1;
                        5'h11: ctrl.alu_op[ALU_SRA] = 1'b1;
                        default: known = 1'b0;
                    endcase
                end else begin
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm = si12;
                    case (op_25_22)
                        4'h8: ctrl.alu_op[ALU_SLT] = 1'b1;
                        4'h9: ctrl.alu_op[ALU_SLTU] = 1'b1;
                        4'ha: ctrl.alu_op[ALU_ADD] = 1'b1;
                        4'hd: ctrl.alu_op[ALU_AND] = 1'b1;
                        4'he: ctrl.alu_op[ALU_OR] = 1'b1;
                        4'hf: ctrl.alu_op[ALU_XOR] = 1'b1;
                        default: known = 1'b0;
                    endcase
                    // logic immediates are zero-extended
                    if (op_25_22 >= 4'hd) begin
                        ctrl.imm = {20'b0, inst[21:10]};
                    end
                end
            end
            OP_LU12I, OP_PCADDU12I: begin
                known = ~inst[25];
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm = ui20;
                ctrl.src1_is_pc = (op_31_26 == OP_PCADDU12I);
                ctrl.alu_op[ALU_LUI] = (op_31_26 == OP_LU12I);
                ctrl.alu_op[ALU_ADD] = (op_31_26 == OP_PCADDU12I);
            end
            OP_MEM: begin
                // address is rj + si12
                ctrl.reads_rj = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm = si12;
                ctrl.alu_op[ALU_ADD] = 1'b1;
                case (op_25_22)
                    4'h0: ctrl.load_op[0] = 1'b1;
                    4'h1: ctrl.load_op[1] = 1'b1;
                    4'h2: ctrl.load_op[2] = 1'b1;
                    4'h8: ctrl.load_op[3] = 1'b1;
                    4'h9: ctrl.load_op[4] = 1'b1;
                    4'h4: ctrl.store_op[0] = 1'b1;
                    4'h5: ctrl.store_op[1] = 1'b1;
                    4'h6: ctrl.store_op[2] = 1'b1;
                    default: known = 1'b0;
                endcase
                ctrl.reads_second = |ctrl.store_op;
            end
            OP_JIRL, OP_BL: begin
                // link value is pc + 4
                ctrl.reads_rj = (op_31_26 == OP_JIRL);
                ctrl.src1_is_pc = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm = 32'd4;
                ctrl.alu_op[ALU_ADD] = 1'b1;
                ctrl.br_kind = (op_31_26 == OP_JIRL) ? BR_JIRL : BR_BL;
                if (op_31_26 == OP_BL) begin
                    ctrl.dest = reg_addr_t'(`ID_LINK_REG);
                end
            end
            OP_B: ctrl.br_kind = BR_B;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                ctrl.reads_rj = 1'b1;
                ctrl.reads_second = 1'b1;
                ctrl.br_kind = br_kind_t'(op_31_26 - OP_BEQ + 6'(BR_BEQ));
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            ctrl = '0;
        end
        ctrl.mem_we = |ctrl.store_op;
        ctrl.gr_we = known && !ctrl.mem_we && ctrl.br_kind != BR_B
                     && !(ctrl.br_kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
                                               BR_BLTU, BR_BGEU});
    end

    assign is_cond = inst[31:26] inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    assign src_is_rd = is_cond || (op_31_26 == OP_MEM && op_25_22 inside {4'h4, 4'h5, 4'h6});
    assign raddr1 = rj;
    assign raddr2 = src_is_rd ? rd : rk;

endmodule

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_config.svh"

module regfile (
    input  logic                 clk,
    input  isa_pkg::reg_addr_t   raddr1,
    input  isa_pkg::reg_addr_t   raddr2,
    output isa_pkg::word_t       rdata1,
    output isa_pkg::word_t       rdata2,
    input  pipe_pkg::wb_bundle_t wb
);
    import isa_pkg::*;

    word_t rf [`ID_NUM_REGS];

    always_ff @(posedge clk) begin
        // r0 is hardwired, never stored
        if (wb.we && wb.waddr != '0) begin
            rf[wb.waddr] <= wb.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

//--- source/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  isa_pkg::reg_addr_t    raddr1,
    input  isa_pkg::reg_addr_t    raddr2,
    input  isa_pkg::word_t        rdata1,
    input  isa_pkg::word_t        rdata2,
    input  pipe_pkg::fwd_bundle_t es_fwd,
    input  pipe_pkg::fwd_bundle_t ms_fwd,
    input  pipe_pkg::wb_bundle_t  wb,
    output isa_pkg::word_t        rj_value,
    output isa_pkg::word_t        rkd_value
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // youngest producer wins
    function automatic word_t pick(input reg_addr_t addr, input word_t rf_data,
                                   input fwd_bundle_t es, input fwd_bundle_t ms,
                                   input wb_bundle_t w);
        word_t val;
        if (es.valid && es.dest != '0 && es.dest == addr) begin
            val = es.data;
        end else if (ms.valid && ms.dest != '0 && ms.dest == addr) begin
            val = ms.data;
        end else if (w.we && w.waddr != '0 && w.waddr == addr) begin
            val = w.wdata;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rj_value = pick(raddr1, rdata1, es_fwd, ms_fwd, wb);
    assign rkd_value = pick(raddr2, rdata2, es_fwd, ms_fwd, wb);

endmodule

`default_nettype wire

//--- source/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_config.svh"

module branch_unit (
    input  isa_pkg::word_t           pc,
    input  logic [25:0]              imm_field,
    input  isa_pkg::br_kind_t        br_kind,
    input  isa_pkg::word_t           rj_value,
    input  isa_pkg::word_t           rkd_value,
    input  logic                     issue_ok,
    input  logic                     hazard,
    input  logic                     es_allowin,
    output pipe_pkg::branch_bundle_t br
);
    import isa_pkg::*;

    logic [`ID_XLEN:0] diff;
    logic              is_eq;
    logic              is_lt;
    logic              is_ltu;
    logic              is_cond;
    logic              cond_met;
    logic              stall;
    logic              taken;
    word_t             offs16;
    word_t             offs26;
    word_t             target;

    // rj - rkd, carry out clear means borrow
    assign diff = {1'b0, rj_value} + {1'b0, ~rkd_value} + 1'b1;
    assign is_eq = (diff[`ID_XLEN-1:0] == '0);
    assign is_ltu = ~diff[`ID_XLEN];
    assign is_lt = (rj_value[`ID_XLEN-1] & ~rkd_value[`ID_XLEN-1])
                 | (~(rj_value[`ID_XLEN-1] ^ rkd_value[`ID_XLEN-1]) & diff[`ID_XLEN-1]);

    assign is_cond = br_kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    always_comb begin
        case (br_kind)
            BR_B, BR_BL, BR_JIRL: cond_met = 1'b1;
            BR_BEQ: cond_met = is_eq;
            BR_BNE: cond_met = ~is_eq;
            BR_BLT: cond_met = is_lt;
            BR_BGE: cond_met = ~is_lt;
            BR_BLTU: cond_met = is_ltu;
            BR_BGEU: cond_met = ~is_ltu;
            default: cond_met = 1'b0;
        endcase
    end

    assign offs16 = {{14{imm_field[15]}}, imm_field[15:0], 2'b0};
    assign offs26 = {{4{imm_field[25]}}, imm_field, 2'b0};
    assign target = (br_kind == BR_JIRL) ? rj_value + offs16
                  : (br_kind == BR_B || br_kind == BR_BL) ? pc + offs26
                  : pc + offs16;

    // compare needs both operands, so wait out a pending load
    assign stall = hazard && is_cond;
    assign taken = cond_met && issue_ok && !stall;

    assign br.stall = stall;
    assign br.taken = taken;
    assign br.cancel = taken && es_allowin;
    assign br.target = issue_ok ? target : '0;

endmodule

`default_nettype wire

//--- id_stage/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fs_to_ds_valid,
    input  pipe_pkg::fetch_bundle_t  fs_to_ds_bus,
    output logic                     ds_allowin,
    input  logic                     es_allowin,
    input  pipe_pkg::fwd_bundle_t    es_fwd,
    input  logic                     es_blk,
    input  pipe_pkg::fwd_bundle_t    ms_fwd,
    input  pipe_pkg::wb_bundle_t     ws_to_rf,
    input  logic                     flush,
    output logic                     ds_to_es_valid,
    output pipe_pkg::issue_bundle_t  ds_to_es_bus,
    output pipe_pkg::branch_bundle_t br_bus
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic          ds_valid;
    logic          ds_ready_go;
    logic          hazard;
    fetch_bundle_t fs_r;
    decode_ctrl_t  ctrl;
    reg_addr_t     raddr1;
    reg_addr_t     raddr2;
    word_t         rdata1;
    word_t         rdata2;
    word_t         rj_value;
    word_t         rkd_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (br_bus.cancel || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_r <= fs_to_ds_bus;
        end
    end

    // load in execute feeding a source we actually read
    assign hazard = ds_valid && es_blk
                    && ((ctrl.reads_rj && es_fwd.dest == raddr1)
                        || (ctrl.reads_second && es_fwd.dest == raddr2));

    assign ds_ready_go = flush || !hazard;
    assign ds_allowin = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go && !flush;

    inst_decoder u_decoder (
        .inst   (fs_r.inst),
        .ctrl   (ctrl),
        .raddr1 (raddr1),
        .raddr2 (raddr2)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (ws_to_rf)
    );

    operand_forward u_forward (
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .wb        (ws_to_rf),
        .rj_value  (rj_value),
        .rkd_value (rkd_value)
    );

    // offs26 layout, low 16 bits double as offs16
    branch_unit u_branch (
        .pc         (fs_r.pc),
        .imm_field  ({fs_r.inst[9:0], fs_r.inst[25:10]}),
        .br_kind    (ctrl.br_kind),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .issue_ok   (ds_to_es_valid),
        .hazard     (hazard),
        .es_allowin (es_allowin),
        .br         (br_bus)
    );

    assign ds_to_es_bus.pc = fs_r.pc;
    assign ds_to_es_bus.rj_value = rj_value;
    assign ds_to_es_bus.rkd_value = rkd_value;
    assign ds_to_es_bus.ctrl = ctrl;

endmodule

`default_nettype wire

//--- verif/id_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_chk (
    input logic                     clk,
    input logic                     reset,
    input logic                     hazard,
    input logic                     flush,
    input logic                     es_allowin,
    input logic                     ds_to_es_valid,
    input pipe_pkg::issue_bundle_t  ds_to_es_bus,
    input pipe_pkg::branch_bundle_t br_bus
);
    import pipe_pkg::*;

    no_issue_on_hazard: assert property (@(posedge clk) disable iff (reset)
        hazard |-> !ds_to_es_valid)
        else $error("issue during load-use hazard");

    cancel_needs_taken: assert property (@(posedge clk) disable iff (reset)
        br_bus.cancel |-> br_bus.taken)
        else $error("cancel without taken");

    // held item must not move under back-pressure
    hold_when_blocked: assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin && !flush)
        |=> ($stable(ds_to_es_bus) && $stable(br_bus) && ds_to_es_valid))
        else $error("outputs changed under back-pressure");

endmodule

bind id_stage id_stage_chk chk_i (
    .clk            (clk),
    .reset          (reset),
    .hazard         (hazard),
    .flush          (flush),
    .es_allowin     (es_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es_bus   (ds_to_es_bus),
    .br_bus         (br_bus)
);

`default_nettype wire

//--- verif/id_stage_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_monitor (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ds_to_es_valid,
    input  logic                     ds_allowin,
    input  logic                     es_allowin,
    input  pipe_pkg::issue_bundle_t  ds_to_es_bus,
    input  pipe_pkg::branch_bundle_t br_bus,
    input  logic [31:0]              exp_pc,
    input  logic [31:0]              exp_rj,
    input  logic [31:0]              exp_rkd,
    input  logic [4:0]               exp_dest,
    input  logic                     exp_gr_we,
    input  logic [31:0]              exp_imm,
    input  logic [11:0]              exp_alu,
    input  logic                     exp_taken,
    input  logic [31:0]              exp_target,
    input  int                       exp_issues,
    input  logic                     expect_stall,
    input  logic                     case_end,
    input  int                       case_num,
    input  logic                     report,
    output int                       issued,
    output int                       errors
);
    import pipe_pkg::*;

    int case_errs;
    int passed;
    int failed;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("** Error at %0t: case %0d %s is %h, expected %h",
                     $time, case_num, what, got, want);
            errors++;
            case_errs++;
        end
    endtask

    initial begin
        issued = 0;
        errors = 0;
        case_errs = 0;
        passed = 0;
        failed = 0;
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (ds_to_es_valid) begin
                check_value("pc", ds_to_es_bus.pc, exp_pc);
                check_value("rj_value", ds_to_es_bus.rj_value, exp_rj);
                check_value("rkd_value", ds_to_es_bus.rkd_value, exp_rkd);
                check_value("dest", 32'(ds_to_es_bus.ctrl.dest), 32'(exp_dest));
                check_value("gr_we", 32'(ds_to_es_bus.ctrl.gr_we), 32'(exp_gr_we));
                check_value("imm", ds_to_es_bus.ctrl.imm, exp_imm);
                check_value("alu_op", 32'(ds_to_es_bus.ctrl.alu_op), 32'(exp_alu));
                check_value("taken", 32'(br_bus.taken), 32'(exp_taken));
                check_value("cancel", 32'(br_bus.cancel), 32'(exp_taken && es_allowin));
                check_value("stall", 32'(br_bus.stall), 32'h0);
                if (exp_taken) begin
                    check_value("target", br_bus.target, exp_target);
                end
                if (!es_allowin && ds_allowin) begin
                    $display("** Error at %0t: case %0d allow-in high under back-pressure",
                             $time, case_num);
                    errors++;
                    case_errs++;
                end
                if (es_allowin) begin
                    issued++;
                end
            end
            if (expect_stall && (ds_to_es_valid || ds_allowin)) begin
                $display("** Error at %0t: case %0d load-use stall not held",
                         $time, case_num);
                errors++;
                case_errs++;
            end
            if (case_end) begin
                check_value("issue count", 32'(issued), 32'(exp_issues));
                if (case_errs == 0) begin
                    $display("case %0d: pass", case_num);
                    passed++;
                end else begin
                    $display("case %0d: fail with %0d errors", case_num, case_errs);
                    failed++;
                end
                issued = 0;
                case_errs = 0;
            end
            if (report) begin
                $display("cases run %0d, passed %0d, failed %0d, errors %0d",
                         passed + failed, passed, failed, errors);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        logic [3:0]  kind;
        logic [31:0] pc;
        logic [31:0] inst;
        fwd_bundle_t es;
        logic        es_blk;
        fwd_bundle_t ms;
        wb_bundle_t  wb;
        logic        es_allowin;
        logic [31:0] rj;
        logic [31:0] rkd;
        logic [4:0]  dest;
        logic        gr_we;
        logic [31:0] imm;
        logic [11:0] alu;
        logic        taken;
        logic [31:0] target;
    } case_t;

    logic           clk;
    logic           reset;
    logic           fs_to_ds_valid;
    fetch_bundle_t  fs_to_ds_bus;
    logic           ds_allowin;
    logic           es_allowin;
    fwd_bundle_t    es_fwd;
    logic           es_blk;
    fwd_bundle_t    ms_fwd;
    wb_bundle_t     ws_to_rf;
    logic           flush;
    logic           ds_to_es_valid;
    issue_bundle_t  ds_to_es_bus;
    branch_bundle_t br_bus;

    case_t cur;
    case_t cases[$];
    int    exp_issues;
    logic  expect_stall;
    logic  case_end;
    logic  report;
    int    case_num;
    int    issued;
    int    errors;
    int    cycles;
    int    limit;

    id_stage id_stage_i (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .es_fwd         (es_fwd),
        .es_blk         (es_blk),
        .ms_fwd         (ms_fwd),
        .ws_to_rf       (ws_to_rf),
        .flush          (flush),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus)
    );

    id_stage_monitor monitor_i (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus),
        .exp_pc         (cur.pc),
        .exp_rj         (cur.rj),
        .exp_rkd        (cur.rkd),
        .exp_dest       (cur.dest),
        .exp_gr_we      (cur.gr_we),
        .exp_imm        (cur.imm),
        .exp_alu        (cur.alu),
        .exp_taken      (cur.taken),
        .exp_target     (cur.target),
        .exp_issues     (exp_issues),
        .expect_stall   (expect_stall),
        .case_end       (case_end),
        .case_num       (case_num),
        .report         (report),
        .issued         (issued),
        .errors         (errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic idle_inputs();
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus = '0;
        es_allowin = 1'b1;
        es_fwd = '0;
        es_blk = 1'b0;
        ms_fwd = '0;
        ws_to_rf = '0;
        flush = 1'b0;
        expect_stall = 1'b0;
        case_end = 1'b0;
        report = 1'b0;
    endtask

    task automatic load_cases();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] v [22];
        case_t       c;
        fd = $fopen("verif/id_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                                  v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17],
                                  v[18], v[19], v[20], v[21]);
                    if (cnt == 22) begin
                        c.kind = v[0][3:0];
                        c.pc = v[1];
                        c.inst = v[2];
                        c.es = {v[3][0], v[4][4:0], v[5]};
                        c.es_blk = v[6][0];
                        c.ms = {v[7][0], v[8][4:0], v[9]};
                        c.wb = {v[10][0], v[11][4:0], v[12]};
                        c.es_allowin = v[13][0];
                        c.rj = v[14];
                        c.rkd = v[15];
                        c.dest = v[16][4:0];
                        c.gr_we = v[17][0];
                        c.imm = v[18];
                        c.alu = v[19][11:0];
                        c.taken = v[20][0];
                        c.target = v[21];
                        cases.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // kind 0 plain, 1 write first, 2 load-use, 3 back-pressure, 4 flush
    task automatic run_case(input case_t c);
        cur = c;
        exp_issues = (c.kind == 4) ? 0 : 1;
        es_fwd = c.es;
        ms_fwd = c.ms;
        es_blk = c.es_blk;
        es_allowin = c.es_allowin;
        if (c.kind == 1) begin
            ws_to_rf = c.wb;
            @(negedge clk);
            ws_to_rf = '0;
        end else begin
            ws_to_rf = c.wb;
        end
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus = {c.pc, c.inst};
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        if (c.kind == 2) begin
            expect_stall = 1'b1;
            repeat (3) @(negedge clk);
            expect_stall = 1'b0;
            es_blk = 1'b0;
        end else if (c.kind == 3) begin
            repeat (3) @(negedge clk);
            es_allowin = 1'b1;
        end else if (c.kind == 4) begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
        end
        if (c.kind != 4) begin
            while (issued == 0) begin
                @(negedge clk);
            end
        end
        case_end = 1'b1;
        @(negedge clk);
        idle_inputs();
    endtask

    initial begin
        reset = 1'b1;
        cycles = 0;
        limit = 1000;
        case_num = 0;
        exp_issues = 0;
        cur = '0;
        idle_inputs();
        void'($urandom(65020));
        load_cases();
        if (cases.size() == 0) begin
            $display("no test cases could be read from verif/id_cases.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            limit = 20 * cases.size() + 100;
            repeat (3) @(negedge clk);
            reset = 1'b0;
            // every register gets a value tied to its number
            for (int n = 1; n < 32; n++) begin
                ws_to_rf = {1'b1, 5'(n), 32'h01010101 * 32'(n)};
                @(negedge clk);
            end
            ws_to_rf = '0;
            foreach (cases[i]) begin
                case_num = i + 1;
                run_case(cases[i]);
                repeat ($urandom_range(3)) @(negedge clk);
            end
            report = 1'b1;
            @(negedge clk);
            report = 1'b0;
            @(negedge clk);
            if (errors == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- id_stage.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
source/inst_decoder.sv
source/regfile.sv
source/operand_forward.sv
source/branch_unit.sv
id_stage/id_stage.sv
verif/id_stage_chk.sv
verif/id_stage_monitor.sv
verif/id_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Icommon
TOP       ?= id_stage_tb
FILELIST  ?= id_stage.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/id_cases.txt
# kind pc inst es_v es_dest es_data es_blk ms_v ms_dest ms_data wb_we wb_addr wb_data es_allowin
# exp_rj exp_rkd exp_dest exp_gr_we exp_imm exp_alu exp_taken exp_target  (all hex)
1 1c000000 001000a4 0 00 00000000 0 0 00 00000000 1 05 12345678 1 12345678 00000000 04 1 00000000 001 0 00000000
1 1c000004 00101404 0 00 00000000 0 0 00 00000000 1 00 deadbeef 1 00000000 12345678 04 1 00000000 001 0 00000000
0 1c000008 001000e4 1 07 aaaa0001 0 1 07 bbbb0002 1 07 cccc0003 1 aaaa0001 00000000 04 1 00000000 001 0 00000000
0 1c00000c 001000e4 0 07 aaaa0001 0 1 07 bbbb0002 1 07 cccc0003 1 bbbb0002 00000000 04 1 00000000 001 0 00000000
0 1c000010 001000e4 0 00 00000000 0 0 00 00000000 0 00 00000000 1 cccc0003 00000000 04 1 00000000 001 0 00000000
0 1c000014 02bf80a4 0 00 00000000 0 0 00 00000000 0 00 00000000 1 12345678 00000000 04 1 ffffffe0 001 0 00000000
0 1c000018 142468a4 0 00 00000000 0 0 00 00000000 0 00 00000000 1 12345678 1a1a1a1a 04 1 12345000 800 0 00000000
0 1c000000 54001000 0 00 00000000 0 0 00 00000000 0 00 00000000 1 00000000 04040404 01 1 00000004 001 1 1c000010
0 1c00001c 298020a6 0 00 00000000 0 0 00 00000000 0 00 00000000 1 12345678 06060606 06 0 00000008 001 0 00000000
0 1c000020 ffffffff 0 00 00000000 0 0 00 00000000 0 00 00000000 1 1f1f1f1f 1f1f1f1f 00 0 00000000 000 0 00000000
2 1c000024 001000a4 1 05 55550005 1 0 00 00000000 0 00 00000000 1 55550005 00000000 04 1 00000000 001 0 00000000
0 1c000100 58000d08 0 00 00000000 0 0 00 00000000 0 00 00000000 1 08080808 08080808 08 0 00000000 000 1 1c00010c
0 1c000104 58000d09 0 00 00000000 0 0 00 00000000 0 00 00000000 1 08080808 09090909 09 0 00000000 000 0 00000000
0 1c000108 4c0008a1 0 00 00000000 0 0 00 00000000 0 00 00000000 1 12345678 02020202 01 1 00000004 001 1 12345680
0 1c000200 60000d4b 1 0a fffffff0 0 1 0b 00000010 0 00 00000000 1 fffffff0 00000010 0b 0 00000000 000 1 1c00020c
0 1c000204 68000d4b 1 0a fffffff0 0 1 0b 00000010 0 00 00000000 1 fffffff0 00000010 0b 0 00000000 000 0 00000000
3 1c000028 001000a4 0 00 00000000 0 0 00 00000000 0 00 00000000 0 12345678 00000000 04 1 00000000 001 0 00000000
4 1c00002c 001000a4 0 00 00000000 0 0 00 00000000 0 00 00000000 1 12345678 00000000 04 1 00000000 001 0 00000000
0 1c000030 001118a4 0 00 00000000 0 0 00 00000000 0 00 00000000 1 12345678 06060606 04 1 00000000 002 0 00000000
